// File: design/panel_defs.svh
/* Panel geometry, pixel size and framebuffer depth macros */

`ifndef PANEL_DEFS_SVH
`define PANEL_DEFS_SVH

// Visible panel area
`define PANEL_COLS 320
`define PANEL_ROWS 16

// Each pixel is stored as this many consecutive bytes
`define BYTES_PER_PIXEL 2

// Address field widths
`define COL_ADDR_BITS 9
`define ROW_ADDR_BITS 4

// Column fields arrive on the byte stream as this many bytes
`define COL_FIELD_BYTES 2

// Total framebuffer size in bytes, rows x cols x bytes per pixel
`define FB_DEPTH 10240

`endif

// File: design/fb_pkg.sv
/* Framebuffer types: column, row and pixel indices, colour,
   byte address and write request */
`default_nettype none

`include "panel_defs.svh"

package fb_pkg;

    typedef logic [`COL_ADDR_BITS-1:0] col_addr_t;
    typedef logic [`ROW_ADDR_BITS-1:0] row_addr_t;
    typedef logic [$clog2(`BYTES_PER_PIXEL)-1:0] pixel_idx_t;

    typedef logic [`BYTES_PER_PIXEL*8-1:0] color_t;

    // Byte address inside the framebuffer
    typedef struct packed {
        row_addr_t row;
        col_addr_t col;
        pixel_idx_t pixel;
    } fb_addr_t;

    // One byte write into the framebuffer
    typedef struct packed {
        fb_addr_t addr;
        logic [7:0] data;
    } fb_write_t;

endpackage

`default_nettype wire

// File: design/cmd_pkg.sv
/* Fill-rectangle command types: raw column field and captured rectangle */
`default_nettype none

`include "panel_defs.svh"

package cmd_pkg;

    // Column values are kept at full received width so that clipping sees them
    typedef logic [`COL_FIELD_BYTES*8-1:0] col_field_t;

    typedef struct packed {
        col_field_t x1;
        col_field_t width;
        logic [7:0] y1;
        logic [7:0] height;
        fb_pkg::color_t color;
    } rect_t;

endpackage

`default_nettype wire

// File: design/byte_field_capture.sv
/* Shift-in capture of a multi-byte command field, first byte most significant */
`default_nettype none

module byte_field_capture #(
    parameter type field_t = logic [7:0]
) (
    input logic clk,
    input logic reset,
    input logic load,
    input logic clear,
    input logic [7:0] data_in,
    output field_t value,
    output logic last
);

    localparam int NUM_BYTES = ($bits(field_t) + 7) / 8;
    localparam int CNT_W = (NUM_BYTES > 1) ? $clog2(NUM_BYTES) : 1;

    logic [CNT_W-1:0] count;
    logic [$bits(field_t)-1:0] shreg;

    assign last = (count == CNT_W'(NUM_BYTES - 1));
    assign value = field_t'(shreg);

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            count <= '0;
            shreg <= '0;
        end else if (load) begin
            // Older bytes move up as each new byte enters at the bottom
            shreg <= ($bits(field_t))'({shreg, data_in});
            if (last) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/subcmd_fillarea.sv
/* Area fill engine: clips a rectangle to the panel and writes its pixel bytes,
   one per cycle */
`default_nettype none

`include "panel_defs.svh"

module subcmd_fillarea (
    input logic clk,
    input logic reset,
    input logic start,
    input cmd_pkg::rect_t rect,
    output fb_pkg::fb_write_t wr,
    output logic wr_en,
    output logic finished
);

    localparam int COL_SUM_W = $bits(cmd_pkg::col_field_t) + 1;
    localparam int ROW_SUM_W = 9;

    typedef logic [COL_SUM_W-1:0] col_sum_t;
    typedef logic [ROW_SUM_W-1:0] row_sum_t;

    col_sum_t col_sum;
    col_sum_t col_end;
    row_sum_t row_sum;
    row_sum_t row_end;
    logic area_empty;

    logic active;
    fb_pkg::col_addr_t col;
    fb_pkg::col_addr_t col_start;
    fb_pkg::col_addr_t col_last;
    fb_pkg::row_addr_t row;
    fb_pkg::row_addr_t row_last;
    fb_pkg::pixel_idx_t pixel;
    fb_pkg::color_t color;

    logic pixel_wrap;
    logic col_wrap;
    logic row_wrap;

    // Clipped end positions, one past the last column and row to write
    assign col_sum = {1'b0, rect.x1} + {1'b0, rect.width};
    assign row_sum = {1'b0, rect.y1} + {1'b0, rect.height};
    assign col_end = (col_sum > col_sum_t'(`PANEL_COLS)) ? col_sum_t'(`PANEL_COLS) : col_sum;
    assign row_end = (row_sum > row_sum_t'(`PANEL_ROWS)) ? row_sum_t'(`PANEL_ROWS) : row_sum;

    // Also covers zero sizes and a start position beyond the panel edge
    assign area_empty = ({1'b0, rect.x1} >= col_end) || ({1'b0, rect.y1} >= row_end);

    assign pixel_wrap = (pixel == fb_pkg::pixel_idx_t'(`BYTES_PER_PIXEL - 1));
    assign col_wrap = (col == col_last);
    assign row_wrap = (row == row_last);

    assign wr_en = active;
    assign wr.addr.row = row;
    assign wr.addr.col = col;
    assign wr.addr.pixel = pixel;
    // Byte index 0 carries the low colour byte
    assign wr.data = color[pixel*8 +: 8];

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            finished <= 1'b0;
        end else begin
            finished <= (start && area_empty) || (active && pixel_wrap && col_wrap && row_wrap);
            if (start) begin
                active <= !area_empty;
            end else if (active && pixel_wrap && col_wrap && row_wrap) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            col <= fb_pkg::col_addr_t'(rect.x1);
            col_start <= fb_pkg::col_addr_t'(rect.x1);
            col_last <= fb_pkg::col_addr_t'(col_end - col_sum_t'(1));
            row <= fb_pkg::row_addr_t'(rect.y1);
            row_last <= fb_pkg::row_addr_t'(row_end - row_sum_t'(1));
            pixel <= '0;
            color <= rect.color;
        end else if (active) begin
            // Pixel byte steps fastest, then column, then row
            if (!pixel_wrap) begin
                pixel <= pixel + 1'b1;
            end else begin
                pixel <= '0;
                if (!col_wrap) begin
                    col <= col + 1'b1;
                end else begin
                    col <= col_start;
                    row <= row + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/cmd_fillrect.sv
/* Fill-rectangle command sequencer: captures the command bytes, runs the
   area fill and signals completion */
`default_nettype none

module cmd_fillrect (
    input logic clk,
    input logic reset,
    input logic [7:0] data_in,
    input logic enable,
    output logic ready_for_data,
    output fb_pkg::fb_write_t wr,
    output logic wr_en,
    output logic done
);

    typedef enum logic [2:0] {
        st_x1,
        st_y1,
        st_width,
        st_height,
        st_color,
        st_start,
        st_running,
        st_done
    } state_t;

    state_t state;

    logic take;
    logic in_x1;
    logic clear_fields;
    logic start;
    logic finished;

    logic load_x1;
    logic load_y1;
    logic load_width;
    logic load_height;
    logic load_color;

    logic x1_last;
    logic y1_last;
    logic width_last;
    logic height_last;
    logic color_last;

    cmd_pkg::col_field_t x1_val;
    cmd_pkg::col_field_t width_val;
    logic [7:0] y1_val;
    logic [7:0] height_val;
    fb_pkg::color_t color_val;
    cmd_pkg::rect_t rect;

    // The done cycle already accepts the first byte of the next command
    assign in_x1 = (state == st_x1) || (state == st_done);
    assign ready_for_data = in_x1 || (state inside {st_y1, st_width, st_height, st_color});
    assign take = enable && ready_for_data;

    assign load_x1 = take && in_x1;
    assign load_y1 = take && (state == st_y1);
    assign load_width = take && (state == st_width);
    assign load_height = take && (state == st_height);
    assign load_color = take && (state == st_color);

    assign start = (state == st_start);
    assign done = (state == st_done);
    assign clear_fields = (state == st_running) && finished;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_x1;
        end else begin
            case (state)
                st_x1: if (load_x1 && x1_last) state <= st_y1;
                st_y1: if (load_y1 && y1_last) state <= st_width;
                st_width: if (load_width && width_last) state <= st_height;
                st_height: if (load_height && height_last) state <= st_color;
                st_color: if (load_color && color_last) state <= st_start;
                st_start: state <= st_running;
                st_running: if (finished) state <= st_done;
                st_done: state <= (load_x1 && x1_last) ? st_y1 : st_x1;
                default: state <= st_x1;
            endcase
        end
    end

    byte_field_capture #(.field_t(cmd_pkg::col_field_t)) x1_capture (
        .clk(clk),
        .reset(reset),
        .load(load_x1),
        .clear(clear_fields),
        .data_in(data_in),
        .value(x1_val),
        .last(x1_last)
    );

    byte_field_capture #(.field_t(logic [7:0])) y1_capture (
        .clk(clk),
        .reset(reset),
        .load(load_y1),
        .clear(clear_fields),
        .data_in(data_in),
        .value(y1_val),
        .last(y1_last)
    );

    byte_field_capture #(.field_t(cmd_pkg::col_field_t)) width_capture (
        .clk(clk),
        .reset(reset),
        .load(load_width),
        .clear(clear_fields),
        .data_in(data_in),
        .value(width_val),
        .last(width_last)
    );

    byte_field_capture #(.field_t(logic [7:0])) height_capture (
        .clk(clk),
        .reset(reset),
        .load(load_height),
        .clear(clear_fields),
        .data_in(data_in),
        .value(height_val),
        .last(height_last)
    );

    byte_field_capture #(.field_t(fb_pkg::color_t)) color_capture (
        .clk(clk),
        .reset(reset),
        .load(load_color),
        .clear(clear_fields),
        .data_in(data_in),
        .value(color_val),
        .last(color_last)
    );

    assign rect = '{
        x1: x1_val,
        width: width_val,
        y1: y1_val,
        height: height_val,
        color: color_val
    };

    subcmd_fillarea fillarea (
        .clk(clk),
        .reset(reset),
        .start(start),
        .rect(rect),
        .wr(wr),
        .wr_en(wr_en),
        .finished(finished)
    );

endmodule

`default_nettype wire

// File: design/framebuffer_ram.sv
/* Byte-wide framebuffer memory with one write port and a registered read port */
`default_nettype none

`include "panel_defs.svh"

module framebuffer_ram (
    input logic clk,
    input fb_pkg::fb_write_t wr,
    input logic wr_en,
    input fb_pkg::fb_addr_t rd_addr,
    output logic [7:0] rd_data
);

    localparam int ADDR_W = $clog2(`FB_DEPTH);

    logic [7:0] mem [`FB_DEPTH];

    logic [ADDR_W-1:0] wr_index;
    logic [ADDR_W-1:0] rd_index;

    // Rows are laid out one after another, pixels contiguous inside a row
    function automatic logic [ADDR_W-1:0] linear_index(input fb_pkg::fb_addr_t a);
        int unsigned idx;
        idx = (32'(a.row) * `PANEL_COLS + 32'(a.col)) * `BYTES_PER_PIXEL + 32'(a.pixel);
        return ADDR_W'(idx);
    endfunction

    assign wr_index = linear_index(wr.addr);
    assign rd_index = linear_index(rd_addr);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_index] <= wr.data;
        end
    end

    // A read in the same cycle as a write to that byte returns the old value
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_index];
    end

endmodule

`default_nettype wire

// File: design/panel_fill_top.sv
/* Top level: fill-rectangle command unit driving the framebuffer memory */
`default_nettype none

module panel_fill_top (
    input logic clk,
    input logic reset,
    input logic [7:0] data_in,
    input logic enable,
    output logic ready_for_data,
    output logic done,
    input fb_pkg::fb_addr_t rd_addr,
    output logic [7:0] rd_data
);

    fb_pkg::fb_write_t wr;
    logic wr_en;

    cmd_fillrect fillrect (
        .clk(clk),
        .reset(reset),
        .data_in(data_in),
        .enable(enable),
        .ready_for_data(ready_for_data),
        .wr(wr),
        .wr_en(wr_en),
        .done(done)
    );

    // The read port is left to whoever consumes the pixels
    framebuffer_ram fb_ram (
        .clk(clk),
        .wr(wr),
        .wr_en(wr_en),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

endmodule

`default_nettype wire

// File: verif/panel_fill_assertions.sv
/* Concurrent assertions on done, ready_for_data and framebuffer writes,
   bound into the top level */
`default_nettype none

`include "panel_defs.svh"

module panel_fill_assertions (
    input logic clk,
    input logic reset,
    input logic ready_for_data,
    input logic done,
    input logic wr_en,
    input fb_pkg::fb_write_t wr
);
    timeunit 1ns;
    timeprecision 100ps;

    int done_fail = 0;
    int overlap_fail = 0;
    int bounds_fail = 0;
    int rise_fail = 0;
    int release_fail = 0;
    int error_count;

    assign error_count = done_fail + overlap_fail + bounds_fail + rise_fail + release_fail;

    done_single_cycle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            done_fail = done_fail + 1;
        end

    no_write_while_ready: assert property (@(posedge clk) disable iff (reset)
        !(wr_en && ready_for_data))
        else begin
            $error("framebuffer write while command bytes are accepted");
            overlap_fail = overlap_fail + 1;
        end

    write_in_panel: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> (wr.addr.col < `PANEL_COLS))
        else begin
            $error("write outside the panel at row %0d col %0d", wr.addr.row, wr.addr.col);
            bounds_fail = bounds_fail + 1;
        end

    ready_rises_with_done: assert property (@(posedge clk) disable iff (reset)
        $rose(ready_for_data) |-> done)
        else begin
            $error("ready_for_data rose without done");
            rise_fail = rise_fail + 1;
        end

    state_after_reset: assert property (@(posedge clk) $fell(reset) |-> ready_for_data && !done)
        else begin
            $error("wrong status in the cycle after reset release");
            release_fail = release_fail + 1;
        end

endmodule

bind panel_fill_top panel_fill_assertions chk (
    .clk(clk),
    .reset(reset),
    .ready_for_data(ready_for_data),
    .done(done),
    .wr_en(wr_en),
    .wr(wr)
);

`default_nettype wire

// File: verif/panel_fill_tb.sv
/* Testbench for panel_fill_top: clock, reset, command stimulus, framebuffer
   reference model, readback comparison and reporting */
`default_nettype none

`include "panel_defs.svh"

module panel_fill_tb;
    timeunit 1ns;
    timeprecision 100ps;

    // Twelve commands, their fills, six full readbacks, then doubled as margin
    localparam int NUM_CMDS = 12;
    localparam int CMD_CYCLES = NUM_CMDS * 16;
    localparam int FILL_CYCLES = `FB_DEPTH + 5 * 2 * 2 + 20 * 2 * 2 + 2 * (8 * 4 * 2)
                                 + 6 * (40 * 8 * 2);
    localparam int READBACK_CYCLES = 6 * (`FB_DEPTH + 2);
    localparam int CYCLE_LIMIT = 2 * (10 + CMD_CYCLES + FILL_CYCLES + READBACK_CYCLES) + 500;

    logic clk;
    logic reset;
    logic [7:0] data_in;
    logic enable;
    logic ready_for_data;
    logic done;
    fb_pkg::fb_addr_t rd_addr;
    logic [7:0] rd_data;

    logic [7:0] model [`FB_DEPTH];
    string test_name;
    int errors = 0;
    int checks = 0;
    int tests_run = 0;
    int test_start_errors = 0;
    int cycle_count = 0;
    int done_count = 0;
    logic [31:0] lcg_state = 32'd72;

    panel_fill_top DUT (
        .clk(clk),
        .reset(reset),
        .data_in(data_in),
        .enable(enable),
        .ready_for_data(ready_for_data),
        .done(done),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (!reset && done) begin
            done_count <= done_count + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic int next_rand(input int limit);
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'((lcg_state >> 16) % 32'(limit));
    endfunction

    task automatic start_test(input string name);
        test_name = name;
        test_start_errors = errors;
    endtask

    task automatic end_test();
        tests_run++;
        $display("Test %s finished with %0d errors", test_name, errors - test_start_errors);
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (expected === actual) else begin
            $display("CHECK FAILED %s: %s expected %0h actual %0h",
                     test_name, what, expected, actual);
            errors++;
        end
    endtask

    // Clip to the panel, low colour byte at pixel index 0
    task automatic apply_model(input int x1, input int y1, input int w, input int h,
                               input logic [15:0] color);
        int col_end;
        int row_end;
        int idx;
        col_end = (x1 + w > `PANEL_COLS) ? `PANEL_COLS : x1 + w;
        row_end = (y1 + h > `PANEL_ROWS) ? `PANEL_ROWS : y1 + h;
        for (int r = y1; r < row_end; r++) begin
            for (int c = x1; c < col_end; c++) begin
                idx = (r * `PANEL_COLS + c) * `BYTES_PER_PIXEL;
                model[idx] = color[7:0];
                model[idx + 1] = color[15:8];
            end
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        while (!ready_for_data) begin
            @(posedge clk);
            #1;
        end
        data_in = b;
        enable = 1'b1;
        @(posedge clk);
        #1;
        enable = 1'b0;
    endtask

    task automatic send_cmd(input int x1, input int y1, input int w, input int h,
                            input logic [15:0] color);
        send_byte(8'(x1 >> 8));
        send_byte(8'(x1));
        send_byte(8'(y1));
        send_byte(8'(w >> 8));
        send_byte(8'(w));
        send_byte(8'(h));
        send_byte(color[15:8]);
        send_byte(color[7:0]);
    endtask

    task automatic wait_done();
        while (!done) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic fill_and_check(input int x1, input int y1, input int w, input int h,
                                  input logic [15:0] color);
        int done_before;
        done_before = done_count;
        apply_model(x1, y1, w, h, color);
        send_cmd(x1, y1, w, h, color);
        wait_done();
        check_value("done pulses", done_before + 1, done_count);
    endtask

    task automatic readback_all();
        int idx;
        for (int r = 0; r < `PANEL_ROWS; r++) begin
            for (int c = 0; c < `PANEL_COLS; c++) begin
                for (int p = 0; p < `BYTES_PER_PIXEL; p++) begin
                    rd_addr.row = fb_pkg::row_addr_t'(r);
                    rd_addr.col = fb_pkg::col_addr_t'(c);
                    rd_addr.pixel = fb_pkg::pixel_idx_t'(p);
                    @(posedge clk);
                    #1;
                    idx = (r * `PANEL_COLS + c) * `BYTES_PER_PIXEL + p;
                    check_value($sformatf("byte %0d", idx), 32'(model[idx]), 32'(rd_data));
                end
            end
        end
    endtask

    initial begin
        int done_before;
        int x1;
        int y1;
        int w;
        int h;
        logic [15:0] color;
        int total;
        clk = 1'b0;
        reset = 1'b1;
        data_in = 8'h00;
        enable = 1'b0;
        rd_addr = '0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        start_test("reset");
        check_value("ready_for_data", 32'd1, 32'(ready_for_data));
        check_value("done", 32'd0, 32'(done));
        end_test();

        // The RAM is not reset, so the whole panel gets a known colour first
        start_test("clear");
        fill_and_check(0, 0, `PANEL_COLS, `PANEL_ROWS, 16'h2B71);
        readback_all();
        end_test();

        start_test("inside");
        fill_and_check(10, 3, 5, 2, 16'hA5C3);
        readback_all();
        end_test();

        start_test("clipping");
        fill_and_check(300, 14, 100, 10, 16'h5A3C);
        readback_all();
        end_test();

        start_test("empty");
        fill_and_check(50, 5, 0, 3, 16'hFFFF);
        readback_all();
        end_test();

        start_test("overlap");
        done_before = done_count;
        apply_model(100, 6, 8, 4, 16'h0F0F);
        apply_model(104, 8, 8, 4, 16'hF0F0);
        send_cmd(100, 6, 8, 4, 16'h0F0F);
        // The first fill is running, so these bytes must be dropped
        for (int i = 0; i < 3; i++) begin
            check_value("ready_for_data during fill", 32'd0, 32'(ready_for_data));
            data_in = 8'hEE;
            enable = 1'b1;
            @(posedge clk);
            #1;
        end
        enable = 1'b0;
        send_cmd(104, 8, 8, 4, 16'hF0F0);
        wait_done();
        check_value("done pulses", done_before + 2, done_count);
        readback_all();
        end_test();

        start_test("random");
        for (int n = 0; n < 6; n++) begin
            x1 = next_rand(400);
            y1 = next_rand(20);
            w = next_rand(41);
            h = next_rand(9);
            color = 16'(next_rand(65536));
            fill_and_check(x1, y1, w, h, color);
        end
        readback_all();
        end_test();

        repeat (2) @(posedge clk);
        total = errors + DUT.chk.error_count;
        $display("Tests run: %0d, checks: %0d, check errors: %0d, assertion failures: %0d",
                 tests_run, checks, errors, DUT.chk.error_count);
        if (total == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: panel_fill_top.f
+incdir+design
design/fb_pkg.sv
design/cmd_pkg.sv
design/byte_field_capture.sv
design/subcmd_fillarea.sv
design/cmd_fillrect.sv
design/framebuffer_ram.sv
design/panel_fill_top.sv
verif/panel_fill_assertions.sv
verif/panel_fill_tb.sv

// File: Makefile
# Verilator build and run for the fill-rectangle command unit

VERILATOR ?= verilator
TOP ?= panel_fill_tb
FILELIST ?= panel_fill_top.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VERILATOR_FLAGS ?= --binary --timing --assert
SIM_ARGS ?= +verilator+error+limit+1000
FAIL_TEXT ?= Simulation FAILED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; \
	status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "Result: failure, see $(LOG)"; \
		exit 1; \
	fi; \
	echo "Result: pass"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
